//--- dv/wbuf_assert.sv
// ######################################################################
// Bound checker for the weight buffer, keeps a shadow of loaded rows
// Configuration is observed on the internal control interface
// Unwritten storage is X in both shadow and DUT, compared with ===
// ######################################################################

`timescale 1ns/1ps

module wbuf_assert #(
  parameter int unsigned  Height = 4,
  parameter int unsigned  NRegs  = 1,
  parameter int unsigned  DataW  = 64,
  localparam int unsigned D      = DataW / wbuf_cfg_pkg::ELEM_W,
  localparam int unsigned RowW   = (Height > 1) ? $clog2(Height) : 1,
  localparam int unsigned EW     = wbuf_cfg_pkg::ELEM_W,
  localparam int unsigned QW     = wbuf_cfg_pkg::QUANT_W
) (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input logic                                   psel_i,
  input logic                                   penable_i,
  input logic                                   pwrite_i,
  input logic [wbuf_ctrl_pkg::APB_ADDR_W-1:0]   paddr_i,
  input logic                                   pready_o,
  input logic                                   pslverr_o,
  input logic [DataW-1:0]                       w_data_i,
  input logic [D*QW-1:0]                        qw_i,
  input logic [D*QW-1:0]                        zeros_i,
  input logic                                   load_i,
  input logic                                   shift_i,
  input logic [RowW-1:0]                        next_gidx_i,
  input logic                                   new_gidx_i,
  input logic                                   w_ready_o,
  input logic [Height-1:0][EW-1:0]              w_o,
  input logic [Height-1:0][QW-1:0]              qw_o,
  input logic [Height-1:0][QW-1:0]              zeros_o,
  input logic                                   dequant_i,
  input logic                                   clear_i,
  input logic [7:0]                             width_i,
  input logic [7:0]                             height_i,
  input logic [Height-1:0]                      mask_i
);

  // Words per stored row: slices times slots
  localparam int unsigned N = ((D + NRegs) / (NRegs + 1)) * (NRegs + 1);

  logic [EW-1:0]               w_mem [Height][N];
  logic [QW-1:0]               qw_mem [Height][N];
  logic [QW-1:0]               z_mem [Height][N];
  logic [Height-1:0][RowW-1:0] raddr_q;
  logic [Height-1:0][RowW-1:0] raddr_nx;
  logic [Height-1:0][EW-1:0]   exp_w;
  logic [Height-1:0][EW-1:0]   exp_w_m;
  logic [Height-1:0][QW-1:0]   exp_qw;
  logic [Height-1:0][QW-1:0]   exp_qw_m;
  logic [Height-1:0][QW-1:0]   exp_z;
  logic [Height-1:0][QW-1:0]   exp_z_m;
  logic [RowW-1:0]             load_cnt;
  logic [RowW-1:0]             wrow;
  logic                        apb_err;
  int unsigned                 k_q;
  int                          fail_count = 0;

  assign wrow = dequant_i ? next_gidx_i : load_cnt; // Scales go to the group row

  assign apb_err = psel_i && penable_i &&
                   (!(paddr_i inside {wbuf_ctrl_pkg::REG_CTRL, wbuf_ctrl_pkg::REG_DIM,
                                      wbuf_ctrl_pkg::REG_MASK, wbuf_ctrl_pkg::REG_STATUS}) ||
                    (pwrite_i && paddr_i == wbuf_ctrl_pkg::REG_STATUS));

  always_comb begin
    raddr_nx = raddr_q;
    if (load_i && dequant_i) begin
      raddr_nx[load_cnt] = next_gidx_i;
    end
  end

  always_comb begin
    for (int h = 0; h < Height; h++) begin
      exp_w_m[h]  = mask_i[h] ? '0 : exp_w[h];
      exp_qw_m[h] = mask_i[h] ? '0 : exp_qw[h];
      exp_z_m[h]  = mask_i[h] ? '0 : exp_z[h];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : shadow
    if (!rst_ni || clear_i) begin
      load_cnt <= '0;
      k_q      <= 0;
      exp_w    <= '0;
      exp_qw   <= '0;
      exp_z    <= '0;
      for (int h = 0; h < Height; h++) begin
        raddr_q[h] <= RowW'(h);
      end
    end else begin
      raddr_q <= raddr_nx;
      if (load_i) begin
        load_cnt <= (load_cnt == RowW'(Height - 1)) ? '0 : load_cnt + 1'b1;
      end
      if (shift_i) begin
        k_q <= (k_q + 1) % N;
        for (int h = 0; h < Height; h++) begin
          exp_w[h]  <= w_mem[raddr_nx[h]][k_q];
          exp_qw[h] <= qw_mem[h][k_q];       // Quantized weights never remap
          exp_z[h]  <= z_mem[raddr_nx[h]][k_q];
        end
      end
      for (int e = 0; e < N; e++) begin
        if (w_ready_o) begin
          w_mem[wrow][e] <= (e < D && e < width_i && load_cnt < height_i) ?
                            w_data_i[e*EW +: EW] : '0;
          z_mem[wrow][e] <= (e < D) ? zeros_i[e*QW +: QW] : '0;
        end
        if (load_i) begin
          qw_mem[load_cnt][e] <= (e < D) ? qw_i[e*QW +: QW] : '0;
        end
      end
    end
  end

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_ready_o == (load_i && !(dequant_i && new_gidx_i)))
    else begin
      fail_count++;
      $error("FAILED w_ready: expected %0b, actual %0b",
             $sampled(load_i && !(dequant_i && new_gidx_i)), $sampled(w_ready_o));
    end

  a_pready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pready_o === 1'b1)
    else begin
      fail_count++;
      $error("FAILED pready: expected 1, actual %b", $sampled(pready_o));
    end

  a_slverr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pslverr_o == apb_err)
    else begin
      fail_count++;
      $error("FAILED pslverr at address %0h: expected %0b, actual %0b",
             $sampled(paddr_i), $sampled(apb_err), $sampled(pslverr_o));
    end

  a_w_out: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_o === exp_w_m)
    else begin
      fail_count++;
      $error("FAILED w_out: expected %0h, actual %0h", $sampled(exp_w_m), $sampled(w_o));
    end

  a_qw_out: assert property (@(posedge clk_i) disable iff (!rst_ni)
    qw_o === exp_qw_m)
    else begin
      fail_count++;
      $error("FAILED qw_out: expected %0h, actual %0h", $sampled(exp_qw_m), $sampled(qw_o));
    end

  a_zeros_out: assert property (@(posedge clk_i) disable iff (!rst_ni)
    zeros_o === exp_z_m)
    else begin
      fail_count++;
      $error("FAILED zeros_out: expected %0h, actual %0h",
             $sampled(exp_z_m), $sampled(zeros_o));
    end

endmodule : wbuf_assert

bind wbuf_top wbuf_assert #(.Height(Height), .NRegs(NRegs), .DataW(DataW)) u_assert (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .psel_i      (psel_i),
  .penable_i   (penable_i),
  .pwrite_i    (pwrite_i),
  .paddr_i     (paddr_i),
  .pready_o    (pready_o),
  .pslverr_o   (pslverr_o),
  .w_data_i    (w_data_i),
  .qw_i        (qw_i),
  .zeros_i     (zeros_i),
  .load_i      (load_i),
  .shift_i     (shift_i),
  .next_gidx_i (next_gidx_i),
  .new_gidx_i  (new_gidx_i),
  .w_ready_o   (w_ready_o),
  .w_o         (w_o),
  .qw_o        (qw_o),
  .zeros_o     (zeros_o),
  .dequant_i   (ctrl_if.dequant),
  .clear_i     (ctrl_if.clear),
  .width_i     (ctrl_if.width),
  .height_i    (ctrl_if.height),
  .mask_i      (ctrl_if.zero_set)
);

//--- dv/wbuf_tb.sv
// ######################################################################
// Testbench for the weight buffer top level
// Output data is checked by the bound assertion module
// An APB access takes three cycles while pready stays high
// ######################################################################

`timescale 1ns/1ps

module wbuf_tb;

  localparam int unsigned Height = wbuf_cfg_pkg::ARRAY_HEIGHT;
  localparam int unsigned NRegs  = wbuf_cfg_pkg::PIPE_REGS;
  localparam int unsigned DataW  = wbuf_cfg_pkg::DATA_W;
  localparam int unsigned D      = DataW / wbuf_cfg_pkg::ELEM_W;
  localparam int unsigned N      = ((D + NRegs) / (NRegs + 1)) * (NRegs + 1);
  localparam int unsigned RowW   = (Height > 1) ? $clog2(Height) : 1;
  localparam int unsigned EW     = wbuf_cfg_pkg::ELEM_W;
  localparam int unsigned QW     = wbuf_cfg_pkg::QUANT_W;
  // Reset, about 30 APB accesses, load bursts and shift bursts
  localparam int unsigned TestCycles = 8 + 30 * 3 + 6 * (Height + 1) + 6 * (2 * N + 1);
  localparam time         TimeoutNs  = (2 * TestCycles + 200) * 40;

  logic                      clk_i = 1'b0;
  logic                      rst_ni;
  logic                      psel_i;
  logic                      penable_i;
  logic                      pwrite_i;
  logic [31:0]               paddr_i;
  logic [31:0]               pwdata_i;
  logic [31:0]               prdata_o;
  logic                      pready_o;
  logic                      pslverr_o;
  logic [DataW-1:0]          w_data_i;
  logic [D*QW-1:0]           qw_i;
  logic [D*QW-1:0]           zeros_i;
  logic                      load_i;
  logic                      shift_i;
  logic [RowW-1:0]           next_gidx_i;
  logic                      new_gidx_i;
  logic                      w_ready_o;
  logic [Height-1:0][EW-1:0] w_o;
  logic [Height-1:0][QW-1:0] qw_o;
  logic [Height-1:0][QW-1:0] zeros_o;
  int unsigned               err_count = 0;

  wbuf_top #(.Height(Height), .NRegs(NRegs), .DataW(DataW)) uut (.*);

  always #20 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      err_count++;
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    while (!pready_o) @(negedge clk_i);
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
  endtask

  task automatic check_reg(input string name, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, 32'h0, rdata, err);
    check_val(name, exp, rdata);
  endtask

  // Back-to-back rows; remap sends row i to group (Height-1-i)/2
  // Plain rows also raise new_gidx_i, which must not stall them
  task automatic load_rows(input int n, input bit remap);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      w_data_i    <= DataW'({$urandom, $urandom});
      qw_i        <= (D*QW)'($urandom);
      zeros_i     <= (D*QW)'($urandom);
      next_gidx_i <= remap ? RowW'((Height - 1 - (i % Height)) / 2) : '0;
      new_gidx_i  <= !remap && (i % 2 == 1);
      load_i      <= 1'b1;
    end
    @(posedge clk_i);
    load_i     <= 1'b0;
    new_gidx_i <= 1'b0;
  endtask

  task automatic shift_n(input int n);
    @(posedge clk_i);
    shift_i <= 1'b1;
    repeat (n - 1) @(posedge clk_i);
    @(posedge clk_i);
    shift_i <= 1'b0;
  endtask

  initial begin : watchdog
    #(TimeoutNs);
    $display("Timeout: run did not finish within %0t", TimeoutNs);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] rdata;
    logic        err;
    int unsigned total;
    void'($urandom(57024));
    rst_ni      = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    w_data_i    = '0;
    qw_i        = '0;
    zeros_i     = '0;
    load_i      = 1'b0;
    shift_i     = 1'b0;
    next_gidx_i = '0;
    new_gidx_i  = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    check_reg("status after reset", wbuf_ctrl_pkg::REG_STATUS, 32'h0);

    // Register read-back and error responses
    reg_write(wbuf_ctrl_pkg::REG_DIM, 32'h0404);
    check_reg("dim readback", wbuf_ctrl_pkg::REG_DIM, 32'h0404);
    reg_write(wbuf_ctrl_pkg::REG_MASK, 32'h5);
    check_reg("mask readback", wbuf_ctrl_pkg::REG_MASK, 32'h5);
    reg_write(wbuf_ctrl_pkg::REG_MASK, 32'h0);
    reg_write(wbuf_ctrl_pkg::REG_CTRL, 32'h1);
    check_reg("ctrl dequant readback", wbuf_ctrl_pkg::REG_CTRL, 32'h1);
    reg_write(wbuf_ctrl_pkg::REG_CTRL, 32'h2);
    check_reg("clear bit reads 0", wbuf_ctrl_pkg::REG_CTRL, 32'h0);
    apb_access(1'b0, 32'h10, 32'h0, rdata, err);
    check_val("unmapped read pslverr", 32'h1, 32'(err));
    apb_access(1'b1, wbuf_ctrl_pkg::REG_STATUS, 32'h1, rdata, err);
    check_val("status write pslverr", 32'h1, 32'(err));

    // Full rows, two passes over the shift sequence
    load_rows(Height, 1'b0);
    shift_n(2 * N);
    check_reg("status after full rows", wbuf_ctrl_pkg::REG_STATUS, 32'h0);

    // Reduced width 2 and height 3
    reg_write(wbuf_ctrl_pkg::REG_DIM, 32'h0302);
    load_rows(Height, 1'b0);
    shift_n(N + 1);

    // Dequant mode with a stalled scale and remapped groups
    reg_write(wbuf_ctrl_pkg::REG_DIM, 32'h0404);
    reg_write(wbuf_ctrl_pkg::REG_CTRL, 32'h1);
    @(posedge clk_i);
    load_i      <= 1'b1;
    new_gidx_i  <= 1'b1;
    next_gidx_i <= RowW'(2);
    @(posedge clk_i);
    load_i     <= 1'b0;
    new_gidx_i <= 1'b0;
    check_reg("status after stall", wbuf_ctrl_pkg::REG_STATUS, 32'h1);
    reg_write(wbuf_ctrl_pkg::REG_CTRL, 32'h3);
    load_rows(Height, 1'b1);
    shift_n(N + 2);
    check_reg("status after dequant", wbuf_ctrl_pkg::REG_STATUS, 32'h0);

    // Zero mask, then clear restarts load counter and shift sequence
    reg_write(wbuf_ctrl_pkg::REG_MASK, 32'h6);
    shift_n(N);
    reg_write(wbuf_ctrl_pkg::REG_MASK, 32'h0);
    reg_write(wbuf_ctrl_pkg::REG_CTRL, 32'h0);
    load_rows(2, 1'b0);
    check_reg("status after two rows", wbuf_ctrl_pkg::REG_STATUS, 32'h2);
    shift_n(3);
    reg_write(wbuf_ctrl_pkg::REG_CTRL, 32'h2);
    check_reg("status after clear", wbuf_ctrl_pkg::REG_STATUS, 32'h0);
    fork
      shift_n(N + 3);
      load_rows(Height, 1'b0);
    join
    shift_n(N);
    repeat (4) @(posedge clk_i);

    total = err_count + uut.u_assert.fail_count;
    $display("Errors: %0d register checks, %0d assertions", err_count, uut.u_assert.fail_count);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : wbuf_tb

//--- verilog/wbuf_apb_regs.sv
// ######################################################################
// APB slave with the buffer configuration
// pready is tied high, so no wait states
// Height must not exceed the 32-bit data bus
// Writing the clear bit gives a one-cycle pulse after the access
// ######################################################################

`timescale 1ns/1ps

module wbuf_apb_regs #(
  parameter int unsigned  Height = wbuf_cfg_pkg::ARRAY_HEIGHT,
  localparam int unsigned CntW   = (Height > 1) ? $clog2(Height) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  psel_i,
  input  logic                                  penable_i,
  input  logic                                  pwrite_i,
  input  logic [wbuf_ctrl_pkg::APB_ADDR_W-1:0]  paddr_i,
  input  logic [wbuf_ctrl_pkg::APB_DATA_W-1:0]  pwdata_i,
  output logic [wbuf_ctrl_pkg::APB_DATA_W-1:0]  prdata_o,
  output logic                                  pready_o,
  output logic                                  pslverr_o,
  wbuf_ctrl_if.regs                             ctrl
);

  localparam int unsigned FieldW = wbuf_ctrl_pkg::DIM_FIELD_W;

  logic              access;
  logic              wr;
  logic              addr_err;
  logic              dequant_q;
  logic              clear_q;
  logic [FieldW-1:0] width_q;
  logic [FieldW-1:0] height_q;
  logic [Height-1:0] mask_q;

  assign access = psel_i & penable_i;
  assign wr     = access & pwrite_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_write
    if (!rst_ni) begin
      dequant_q <= 1'b0;
      clear_q   <= 1'b0;
      width_q   <= '0;
      height_q  <= '0;
      mask_q    <= '0;
    end else begin
      clear_q <= wr && (paddr_i == wbuf_ctrl_pkg::REG_CTRL) &&
                 pwdata_i[wbuf_ctrl_pkg::CTRL_CLEAR];
      if (wr && paddr_i == wbuf_ctrl_pkg::REG_CTRL) begin
        dequant_q <= pwdata_i[wbuf_ctrl_pkg::CTRL_DEQUANT];
      end
      if (wr && paddr_i == wbuf_ctrl_pkg::REG_DIM) begin
        width_q  <= pwdata_i[wbuf_ctrl_pkg::DIM_WIDTH_LSB +: FieldW];
        height_q <= pwdata_i[wbuf_ctrl_pkg::DIM_HEIGHT_LSB +: FieldW];
      end
      if (wr && paddr_i == wbuf_ctrl_pkg::REG_MASK) begin
        mask_q <= pwdata_i[Height-1:0];
      end
    end
  end

  always_comb begin : reg_read
    prdata_o = '0;
    addr_err = 1'b0;
    case (paddr_i)
      wbuf_ctrl_pkg::REG_CTRL:   prdata_o[wbuf_ctrl_pkg::CTRL_DEQUANT] = dequant_q;
      wbuf_ctrl_pkg::REG_DIM: begin
        prdata_o[wbuf_ctrl_pkg::DIM_WIDTH_LSB +: FieldW]  = width_q;
        prdata_o[wbuf_ctrl_pkg::DIM_HEIGHT_LSB +: FieldW] = height_q;
      end
      wbuf_ctrl_pkg::REG_MASK:   prdata_o[Height-1:0] = mask_q;
      wbuf_ctrl_pkg::REG_STATUS: begin
        prdata_o[CntW-1:0] = ctrl.load_count;
        addr_err           = pwrite_i; // Status is read only
      end
      default:                   addr_err = 1'b1;
    endcase
  end

  assign pready_o  = 1'b1;
  assign pslverr_o = access & addr_err;

  assign ctrl.dequant  = dequant_q;
  assign ctrl.clear    = clear_q;
  assign ctrl.width    = width_q;
  assign ctrl.height   = height_q;
  assign ctrl.zero_set = mask_q;

endmodule : wbuf_apb_regs

//--- verilog/wbuf_cfg_pkg.sv
// ######################################################################
// Size defaults and element widths of the weight buffer
// Only 16-bit elements are supported, and quantized values are 8 bits
// DATA_W must be a multiple of ELEM_W
// ######################################################################

package wbuf_cfg_pkg;

  // Number of PE rows
  parameter int unsigned ARRAY_HEIGHT = 4;
  // Pipeline registers inside each PE
  parameter int unsigned PIPE_REGS = 1;
  // Width of the row stream in bits
  parameter int unsigned DATA_W = 64;

  parameter int unsigned ELEM_W = 16;
  parameter int unsigned QUANT_W = 8; // Quantized weight or zero point

endpackage : wbuf_cfg_pkg

//--- verilog/wbuf_ctrl_if.sv
// ######################################################################
// Control and status between register block and buffer
// clear is a single-cycle pulse
// ######################################################################

`timescale 1ns/1ps

interface wbuf_ctrl_if #(
  parameter int unsigned Height = wbuf_cfg_pkg::ARRAY_HEIGHT
);

  localparam int unsigned CntW = (Height > 1) ? $clog2(Height) : 1;

  logic                                   dequant;
  logic                                   clear;
  logic [wbuf_ctrl_pkg::DIM_FIELD_W-1:0]  width;   // Valid elements per row
  logic [wbuf_ctrl_pkg::DIM_FIELD_W-1:0]  height;  // Valid rows
  logic [Height-1:0]                      zero_set;
  logic [CntW-1:0]                        load_count;

  modport regs (output dequant, clear, width, height, zero_set, input load_count);
  modport buffer (input dequant, clear, width, height, zero_set, output load_count);

endinterface : wbuf_ctrl_if

//--- verilog/wbuf_ctrl_pkg.sv
// ######################################################################
// APB register map of the weight buffer
// All registers are 32 bits wide and word aligned
// Any address outside the map answers with pslverr
// ######################################################################

package wbuf_ctrl_pkg;

  parameter int unsigned APB_ADDR_W = 32;
  parameter int unsigned APB_DATA_W = 32;

  parameter logic [APB_ADDR_W-1:0] REG_CTRL = 32'h0;
  parameter logic [APB_ADDR_W-1:0] REG_DIM = 32'h4;
  parameter logic [APB_ADDR_W-1:0] REG_MASK = 32'h8;
  parameter logic [APB_ADDR_W-1:0] REG_STATUS = 32'hC; // Read only

  // REG_CTRL bits
  parameter int unsigned CTRL_DEQUANT = 0;
  parameter int unsigned CTRL_CLEAR = 1; // Self clearing, reads 0

  // REG_DIM fields
  parameter int unsigned DIM_WIDTH_LSB = 0;
  parameter int unsigned DIM_HEIGHT_LSB = 8;
  parameter int unsigned DIM_FIELD_W = 8;

endpackage : wbuf_ctrl_pkg

//--- verilog/wbuf_scm.sv
// ######################################################################
// Rows x slices x slots word storage, one registered read per row
// Storage is built from flip-flops and holds X until written
// Read indices must stay inside Cols and Elms
// ######################################################################

`timescale 1ns/1ps

module wbuf_scm #(
  parameter int unsigned  WordW = 16,
  parameter int unsigned  Rows  = 4,
  parameter int unsigned  Cols  = 2,
  parameter int unsigned  Elms  = 2,
  localparam int unsigned RowW  = (Rows > 1) ? $clog2(Rows) : 1,
  localparam int unsigned ColW  = (Cols > 1) ? $clog2(Cols) : 1,
  localparam int unsigned ElmW  = (Elms > 1) ? $clog2(Elms) : 1
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  input  logic                              write_en_i,
  input  logic [RowW-1:0]                   write_addr_i,
  input  logic [Cols*Elms-1:0][WordW-1:0]   wdata_i,
  input  logic                              read_en_i,
  input  logic [ElmW-1:0]                   elm_addr_i,
  input  logic [ColW-1:0]                   col_offs_i,
  input  logic [Rows-1:0][RowW-1:0]         row_addr_i,
  output logic [Rows-1:0][WordW-1:0]        rdata_o
);

  // Word c*Elms+e of a row sits at slice c, slot e
  logic [Cols-1:0][Elms-1:0][WordW-1:0] mem_q [Rows];
  logic [Rows-1:0][WordW-1:0]           rdata_q;

  always_ff @(posedge clk_i) begin : array_write
    if (write_en_i) begin
      mem_q[write_addr_i] <= wdata_i;
    end
  end

  for (genvar h = 0; h < Rows; h++) begin : gen_read
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rdata_q[h] <= '0;
      end else if (clear_i) begin
        rdata_q[h] <= '0;
      end else if (read_en_i) begin
        // Each output row has its own row address
        rdata_q[h] <= mem_q[row_addr_i[h]][col_offs_i][elm_addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule : wbuf_scm

//--- verilog/wbuf_top.sv
// ######################################################################
// Weight buffer top level with APB configuration port
// Height >= 2 assumed, DataW a multiple of the 16-bit element
// ######################################################################

`timescale 1ns/1ps

module wbuf_top #(
  parameter int unsigned  Height = wbuf_cfg_pkg::ARRAY_HEIGHT,
  parameter int unsigned  NRegs  = wbuf_cfg_pkg::PIPE_REGS,
  parameter int unsigned  DataW  = wbuf_cfg_pkg::DATA_W,
  localparam int unsigned D      = DataW / wbuf_cfg_pkg::ELEM_W,
  localparam int unsigned RowW   = (Height > 1) ? $clog2(Height) : 1
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          psel_i,
  input  logic                                          penable_i,
  input  logic                                          pwrite_i,
  input  logic [wbuf_ctrl_pkg::APB_ADDR_W-1:0]          paddr_i,
  input  logic [wbuf_ctrl_pkg::APB_DATA_W-1:0]          pwdata_i,
  output logic [wbuf_ctrl_pkg::APB_DATA_W-1:0]          prdata_o,
  output logic                                          pready_o,
  output logic                                          pslverr_o,
  input  logic [DataW-1:0]                              w_data_i,
  input  logic [D*wbuf_cfg_pkg::QUANT_W-1:0]            qw_i,
  input  logic [D*wbuf_cfg_pkg::QUANT_W-1:0]            zeros_i,
  input  logic                                          load_i,
  input  logic                                          shift_i,
  input  logic [RowW-1:0]                               next_gidx_i,
  input  logic                                          new_gidx_i,
  output logic                                          w_ready_o,
  output logic [Height-1:0][wbuf_cfg_pkg::ELEM_W-1:0]   w_o,
  output logic [Height-1:0][wbuf_cfg_pkg::QUANT_W-1:0]  qw_o,
  output logic [Height-1:0][wbuf_cfg_pkg::QUANT_W-1:0]  zeros_o
);

  wbuf_ctrl_if #(.Height(Height)) ctrl_if ();

  wbuf_apb_regs #(.Height(Height)) u_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .ctrl      (ctrl_if)
  );

  wbuf_w_buffer #(.Height(Height), .NRegs(NRegs), .DataW(DataW)) u_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ctrl        (ctrl_if),
    .w_data_i    (w_data_i),
    .qw_i        (qw_i),
    .zeros_i     (zeros_i),
    .load_i      (load_i),
    .shift_i     (shift_i),
    .next_gidx_i (next_gidx_i),
    .new_gidx_i  (new_gidx_i),
    .w_ready_o   (w_ready_o),
    .w_o         (w_o),
    .qw_o        (qw_o),
    .zeros_o     (zeros_o)
  );

endmodule : wbuf_top

//--- verilog/wbuf_w_buffer.sv
// ######################################################################
// Weight buffer with zero padding, group-index addressing and masking
// The load counter advances on every load_i cycle, accepted or not
// Quantized weights always go to and come from row load_count / h
// Width and height act on weights and scales only
// ######################################################################

`timescale 1ns/1ps

module wbuf_w_buffer #(
  parameter int unsigned  Height = wbuf_cfg_pkg::ARRAY_HEIGHT,
  parameter int unsigned  NRegs  = wbuf_cfg_pkg::PIPE_REGS,
  parameter int unsigned  DataW  = wbuf_cfg_pkg::DATA_W,
  localparam int unsigned D      = DataW / wbuf_cfg_pkg::ELEM_W,
  localparam int unsigned RowW   = (Height > 1) ? $clog2(Height) : 1
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  wbuf_ctrl_if.buffer                                   ctrl,
  input  logic [DataW-1:0]                              w_data_i,
  input  logic [D*wbuf_cfg_pkg::QUANT_W-1:0]            qw_i,
  input  logic [D*wbuf_cfg_pkg::QUANT_W-1:0]            zeros_i,
  input  logic                                          load_i,
  input  logic                                          shift_i,
  input  logic [RowW-1:0]                               next_gidx_i,
  input  logic                                          new_gidx_i,
  output logic                                          w_ready_o,
  output logic [Height-1:0][wbuf_cfg_pkg::ELEM_W-1:0]   w_o,
  output logic [Height-1:0][wbuf_cfg_pkg::QUANT_W-1:0]  qw_o,
  output logic [Height-1:0][wbuf_cfg_pkg::QUANT_W-1:0]  zeros_o
);

  localparam int unsigned EW    = wbuf_cfg_pkg::ELEM_W;
  localparam int unsigned QW    = wbuf_cfg_pkg::QUANT_W;
  localparam int unsigned Slots = NRegs + 1;
  localparam int unsigned C     = (D + NRegs) / (NRegs + 1);
  localparam int unsigned N     = C * Slots;   // Stored words per row, D rounded up
  localparam int unsigned SlotW = (Slots > 1) ? $clog2(Slots) : 1;
  localparam int unsigned ColW  = (C > 1) ? $clog2(C) : 1;

  logic [N-1:0][EW-1:0]         w_pad;
  logic [N*QW-1:0]              qw_pad;
  logic [N*QW-1:0]              zeros_pad;
  logic                         row_in;
  logic                         write_en;
  logic [RowW-1:0]              write_addr;
  logic [RowW-1:0]              load_cnt_q;
  logic [SlotW-1:0]             slot_d, slot_q;
  logic [ColW-1:0]              col_d, col_q;
  logic [Height-1:0][RowW-1:0]  raddr_d, raddr_q;
  logic [Height-1:0][RowW-1:0]  qw_raddr;
  logic [Height-1:0][EW-1:0]    w_q;
  logic [Height-1:0][QW-1:0]    qw_q;
  logic [Height-1:0][QW-1:0]    zeros_q;

  assign row_in = load_cnt_q < ctrl.height;

  for (genvar d = 0; d < N; d++) begin : gen_pad
    if (d < D) begin : gen_elem
      assign w_pad[d] = (d < ctrl.width && row_in) ? w_data_i[d*EW +: EW] : '0;
    end else begin : gen_fill
      assign w_pad[d] = '0;
    end
  end

  assign qw_pad    = (N*QW)'(qw_i);
  assign zeros_pad = (N*QW)'(zeros_i);

  // A new group index stalls the scale write for one cycle
  assign write_en   = load_i & (~ctrl.dequant | ~new_gidx_i);
  assign write_addr = ctrl.dequant ? next_gidx_i : load_cnt_q;
  assign w_ready_o  = write_en;

  for (genvar h = 0; h < Height; h++) begin : gen_raddr
    assign qw_raddr[h] = RowW'(h);

    always_comb begin
      raddr_d[h] = raddr_q[h];
      if (load_i && ctrl.dequant && load_cnt_q == RowW'(h)) begin
        raddr_d[h] = next_gidx_i;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        raddr_q[h] <= RowW'(h);
      end else if (ctrl.clear) begin
        raddr_q[h] <= RowW'(h);
      end else begin
        raddr_q[h] <= raddr_d[h];
      end
    end
  end

  assign slot_d = (slot_q == SlotW'(NRegs)) ? '0 : slot_q + 1'b1;
  assign col_d  = (slot_q != SlotW'(NRegs)) ? col_q :
                  (col_q == ColW'(C - 1))   ? '0    : col_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin : shift_counters
    if (!rst_ni) begin
      slot_q <= '0;
      col_q  <= '0;
    end else if (ctrl.clear) begin
      slot_q <= '0;
      col_q  <= '0;
    end else if (shift_i) begin
      slot_q <= slot_d;
      col_q  <= col_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : row_load_counter
    if (!rst_ni) begin
      load_cnt_q <= '0;
    end else if (ctrl.clear) begin
      load_cnt_q <= '0;
    end else if (load_i) begin
      load_cnt_q <= (load_cnt_q == RowW'(Height - 1)) ? '0 : load_cnt_q + 1'b1;
    end
  end

  assign ctrl.load_count = load_cnt_q;

  wbuf_scm #(.WordW(EW), .Rows(Height), .Cols(C), .Elms(Slots)) u_w_scm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (ctrl.clear),
    .write_en_i   (write_en),
    .write_addr_i (write_addr),
    .wdata_i      (w_pad),
    .read_en_i    (shift_i),
    .elm_addr_i   (slot_q),
    .col_offs_i   (col_q),
    .row_addr_i   (raddr_d),
    .rdata_o      (w_q)
  );

  wbuf_scm #(.WordW(QW), .Rows(Height), .Cols(C), .Elms(Slots)) u_zeros_scm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (ctrl.clear),
    .write_en_i   (write_en),
    .write_addr_i (write_addr),
    .wdata_i      (zeros_pad),
    .read_en_i    (shift_i),
    .elm_addr_i   (slot_q),
    .col_offs_i   (col_q),
    .row_addr_i   (raddr_d),
    .rdata_o      (zeros_q)
  );

  wbuf_scm #(.WordW(QW), .Rows(Height), .Cols(C), .Elms(Slots)) u_qw_scm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (ctrl.clear),
    .write_en_i   (load_i),
    .write_addr_i (load_cnt_q),
    .wdata_i      (qw_pad),
    .read_en_i    (shift_i),
    .elm_addr_i   (slot_q),
    .col_offs_i   (col_q),
    .row_addr_i   (qw_raddr),
    .rdata_o      (qw_q)
  );

  always_comb begin : output_mask
    w_o     = w_q;
    qw_o    = qw_q;
    zeros_o = zeros_q;
    for (int unsigned i = 0; i < Height; i++) begin
      if (ctrl.zero_set[i]) begin
        w_o[i]     = '0;
        qw_o[i]    = '0;
        zeros_o[i] = '0;
      end
    end
  end

endmodule : wbuf_w_buffer

//--- wbuf.f
verilog/wbuf_cfg_pkg.sv
verilog/wbuf_ctrl_pkg.sv
verilog/wbuf_ctrl_if.sv
verilog/wbuf_scm.sv
verilog/wbuf_apb_regs.sv
verilog/wbuf_w_buffer.sv
verilog/wbuf_top.sv
dv/wbuf_assert.sv
dv/wbuf_tb.sv
